// File: logic/cacheController.sv
`timescale 1ns/10ps

// Sequencer for the CPU slave port and the memory master port
// A miss reads the whole block word by word and then installs the tag
module cacheController (
  input  logic                        clk,
  input  logic                        arstN,
  // CPU side Wishbone classic slave
  input  logic                        cpuCyc,
  input  logic                        cpuStb,
  input  logic [cachePkg::addrW-1:0]  cpuAdr,
  output logic                        cpuAck,
  output logic [cachePkg::dataW-1:0]  cpuDatOut,
  // Core lookup results
  input  logic                        hit,
  input  logic [cachePkg::dataW-1:0]  coreData,
  // Core lookup and write controls
  output logic [cachePkg::tagW-1:0]   tag,
  output logic [cachePkg::setW-1:0]   setIndex,
  output logic [cachePkg::wordW-1:0]  wordIndex,
  output logic [cachePkg::dataW-1:0]  fillData,
  output logic                        dataWrite,
  output logic                        metaWrite,
  // Memory side Wishbone classic master
  output logic                        memCyc,
  output logic                        memStb,
  output logic [cachePkg::addrW-1:0]  memAdr,
  input  logic [cachePkg::dataW-1:0]  memDatIn,
  input  logic                        memAck
);
  import cachePkg::*;

  typedef enum logic [2:0] {
    idle,       // Waiting for cyc and stb
    lookup,     // Core compares the held address
    fetch,      // memStb up until memAck
    fetchGap,   // One cycle with memStb low between words
    tagUpdate   // Block complete so the tag is installed
  } stateT;

  localparam logic [wordW-1:0] lastWord = wordW'(blockWords - 1);

  stateT            state;
  stateT            stateNext;
  logic [addrW-1:0] reqAdr;   // CPU address held for the whole access
  logic [wordW-1:0] fillCnt;  // Word of the block being fetched

  //////////////////////////////////////////////////////////////////////
  // State and fill counter
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= idle;
      fillCnt <= '0;
    end else begin
      state <= stateNext;
      if (state == lookup) begin
        fillCnt <= '0;  // Every fill starts at word 0 of the block
      end else if (state == fetch && memAck) begin
        fillCnt <= fillCnt + 1'b1;
      end
    end
  end

  // The master keeps the address steady until ack, so one capture is enough
  always_ff @(posedge clk) begin
    if (state == idle && cpuCyc && cpuStb) begin
      reqAdr <= cpuAdr;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      idle: begin
        if (cpuCyc && cpuStb) begin
          stateNext = lookup;
        end
      end
      lookup:    stateNext = hit ? idle : fetch;  // Ack on a hit, otherwise fill
      fetch: begin
        if (memAck) begin
          stateNext = (fillCnt == lastWord) ? tagUpdate : fetchGap;
        end
      end
      fetchGap:  stateNext = fetch;
      tagUpdate: stateNext = lookup;              // Repeat the lookup, which now hits
      default:   stateNext = idle;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Core controls
  //////////////////////////////////////////////////////////////////////
  assign tag       = reqAdr[addrW-1 -: tagW];
  assign setIndex  = reqAdr[wordW +: setW];
  assign wordIndex = (state == fetch) ? fillCnt : reqAdr[wordW-1:0];
  assign fillData  = memDatIn;                     // Written on the memAck cycle
  assign dataWrite = (state == fetch) && memAck;

  // LRU refresh on every hit and tag install at the end of a fill
  assign metaWrite = cpuAck || (state == tagUpdate);

  //////////////////////////////////////////////////////////////////////
  // Bus outputs
  //////////////////////////////////////////////////////////////////////
  assign cpuAck    = (state == lookup) && hit;     // One cycle, FSM leaves lookup
  assign cpuDatOut = coreData;

  assign memCyc = (state == fetch) || (state == fetchGap);  // Held across the block
  assign memStb = (state == fetch);
  assign memAdr = {tag, setIndex, fillCnt};

endmodule

// File: logic/cacheCore.sv
`timescale 1ns/10ps

// Lookup datapath of the 2-way cache
// Everything from the lookup fields to hit and dataOut is combinational
module cacheCore (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic [cachePkg::tagW-1:0]  tag,        // Tag field of the lookup address
  input  logic [cachePkg::setW-1:0]  setIndex,   // Set being looked up or filled
  input  logic [cachePkg::wordW-1:0] wordIndex,  // Word for the data array
  input  logic [cachePkg::dataW-1:0] fillData,   // Word returned by memory
  input  logic                       dataWrite,  // Store fillData in the chosen way
  input  logic                       metaWrite,  // Store next metadata for both ways
  output logic                       hit,
  output logic [cachePkg::dataW-1:0] dataOut
);
  import cachePkg::*;

  typedef logic [dataW-1:0] wordT;  // Payload of the data array

  metaEntryT meta0;      // Stored entry of way 0 for this set
  metaEntryT meta1;      // Stored entry of way 1 for this set
  metaEntryT metaNext0;  // Entry written to way 0 on metaWrite
  metaEntryT metaNext1;  // Entry written to way 1 on metaWrite
  wordT      data0;      // Word held in way 0
  wordT      data1;      // Word held in way 1
  logic      match0;     // Way 0 holds the requested block
  logic      match1;     // Way 1 holds the requested block
  logic      evictWay;   // Victim when the lookup misses
  logic      waySel;     // Way touched by this access

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////
  wayArray #(
    .entryT(wordT),
    .depth (numSets * blockWords)
  ) dataWays (
    .clk      (clk),
    .arstN    (arstN),
    .index    ({setIndex, wordIndex}),  // Set and word pick one of 512 words
    .writeEn  (dataWrite),
    .writeWay ({waySel, ~waySel}),      // Only the chosen way takes the word
    .writeData({fillData, fillData}),
    .readWay0 (data0),
    .readWay1 (data1)
  );

  wayArray #(
    .entryT(metaEntryT),
    .depth (numSets)
  ) metaWays (
    .clk      (clk),
    .arstN    (arstN),
    .index    (setIndex),
    .writeEn  (metaWrite),
    .writeWay (2'b11),                  // LRU update touches both ways of the set
    .writeData({metaNext1, metaNext0}),
    .readWay0 (meta0),
    .readWay1 (meta1)
  );

  //////////////////////////////////////////////////////////////////////
  // Tag compare and way choice
  //////////////////////////////////////////////////////////////////////
  assign match0 = meta0.valid && (meta0.tag == tag);
  assign match1 = meta1.valid && (meta1.tag == tag);
  assign hit    = match0 || match1;

  // Way 0 goes when its lru bit is set, otherwise way 1 is the victim
  assign evictWay = ~meta0.lru;
  assign waySel   = hit ? match1 : evictWay;  // Stays on the victim for the whole fill

  // The touched way ends up holding this tag as most recent, on a hit as well as
  // after a fill, while the other way keeps its contents and becomes the victim
  assign metaNext0 = (waySel == 1'b0) ? '{tag: tag, valid: 1'b1, lru: 1'b0}
                                      : '{tag: meta0.tag, valid: meta0.valid, lru: 1'b1};
  assign metaNext1 = (waySel == 1'b1) ? '{tag: tag, valid: 1'b1, lru: 1'b0}
                                      : '{tag: meta1.tag, valid: meta1.valid, lru: 1'b1};

  // Word from the matching way, zero on a miss
  assign dataOut = hit ? (match1 ? data1 : data0) : '0;

endmodule

// File: logic/cachePkg.sv
package cachePkg;

  // Word address layout from the top down is tag, set index, word in block
  localparam int tagW  = 6;                     // Tag bits kept in each way
  localparam int setW  = 6;                     // Selects one of the sets
  localparam int wordW = 3;                     // Selects a word inside a block
  localparam int addrW = tagW + setW + wordW;   // Full 15-bit word address

  localparam int dataW = 16;                    // Every access moves one 16-bit word

  // Derived geometry
  localparam int numSets    = 1 << setW;        // 64 sets of two ways
  localparam int blockWords = 1 << wordW;       // 8 words fetched per fill

  // One metadata entry per way per set, 8 bits in all
  typedef struct packed {
    logic [tagW-1:0] tag;    // Tag of the block held in this way
    logic            valid;  // Way holds a complete block
    logic            lru;    // Set when this way is the next victim
  } metaEntryT;

endpackage

// File: logic/cacheTop.sv
`timescale 1ns/10ps

// Read-only 2-way cache between a CPU Wishbone slave and a memory Wishbone master
module cacheTop (
  input  logic                       clk,
  input  logic                       arstN,
  // CPU side
  input  logic                       cpuCyc,
  input  logic                       cpuStb,
  input  logic [cachePkg::addrW-1:0] cpuAdr,
  output logic [cachePkg::dataW-1:0] cpuDatOut,
  output logic                       cpuAck,
  // Memory side
  output logic                       memCyc,
  output logic                       memStb,
  output logic [cachePkg::addrW-1:0] memAdr,
  input  logic [cachePkg::dataW-1:0] memDatIn,
  input  logic                       memAck
);
  import cachePkg::*;

  logic [tagW-1:0]  tag;        // Lookup fields from the controller
  logic [setW-1:0]  setIndex;
  logic [wordW-1:0] wordIndex;
  logic [dataW-1:0] fillData;   // Memory word on its way into the data array
  logic             dataWrite;
  logic             metaWrite;
  logic             hit;
  logic [dataW-1:0] coreData;   // Word from the hitting way

  cacheCore core (
    .clk      (clk),
    .arstN    (arstN),
    .tag      (tag),
    .setIndex (setIndex),
    .wordIndex(wordIndex),
    .fillData (fillData),
    .dataWrite(dataWrite),
    .metaWrite(metaWrite),
    .hit      (hit),
    .dataOut  (coreData)
  );

  cacheController controller (
    .clk      (clk),
    .arstN    (arstN),
    .cpuCyc   (cpuCyc),
    .cpuStb   (cpuStb),
    .cpuAdr   (cpuAdr),
    .cpuAck   (cpuAck),
    .cpuDatOut(cpuDatOut),
    .hit      (hit),
    .coreData (coreData),
    .tag      (tag),
    .setIndex (setIndex),
    .wordIndex(wordIndex),
    .fillData (fillData),
    .dataWrite(dataWrite),
    .metaWrite(metaWrite),
    .memCyc   (memCyc),
    .memStb   (memStb),
    .memAdr   (memAdr),
    .memDatIn (memDatIn),
    .memAck   (memAck)
  );

endmodule

// File: logic/wayArray.sv
`timescale 1ns/10ps

// Two-way storage built from flops
// Both ways are read at the same index and each way has its own write enable
module wayArray #(
  parameter type entryT = logic [7:0],  // Payload of one entry
  parameter int  depth  = 64            // Entries in each way
) (
  input  logic                     clk,
  input  logic                     arstN,
  input  logic [$clog2(depth)-1:0] index,      // Shared read and write index
  input  logic                     writeEn,    // Write strobe for this cycle
  input  logic [1:0]               writeWay,   // Per-way enable, bit 0 is way 0
  input  entryT [1:0]              writeData,  // Per-way payload, element 0 is way 0
  output entryT                    readWay0,
  output entryT                    readWay1
);

  entryT store [2][depth];  // Index 0 is way 0

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      // Every entry starts cleared so metadata comes up invalid
      for (int i = 0; i < depth; i++) begin
        store[0][i] <= '0;
        store[1][i] <= '0;
      end
    end else if (writeEn) begin
      for (int w = 0; w < 2; w++) begin
        if (writeWay[w]) begin
          store[w][index] <= writeData[w];  // Lands at this edge, visible next cycle
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////
  assign readWay0 = store[0][index];  // Combinational read of way 0
  assign readWay1 = store[1][index];  // Combinational read of way 1

endmodule

// File: run.sh
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_TEXT="Simulation completed successfully"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f sim.f --top-module cacheTb -Mdir obj_dir -o cacheSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cacheSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "^${PASS_TEXT}\$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: sim.f
logic/cachePkg.sv
logic/wayArray.sv
logic/cacheCore.sv
logic/cacheController.sv
logic/cacheTop.sv
sim/wbMemory.sv
sim/cacheTb.sv

// File: sim/cacheTb.sv
`timescale 1ns/10ps

// Testbench for the 2-way read-only cache
// A reference copy of tags, valid and lru bits predicts every read
module cacheTb;
  import cachePkg::*;

  localparam logic [dataW-1:0] dataKey = 16'h5A3C;  // Memory word is address XOR key
  localparam int ackTimeout = 200;                  // Cycles allowed for one read

  logic             clk;
  logic             arstN;
  logic             cpuCyc;
  logic             cpuStb;
  logic [addrW-1:0] cpuAdr;
  logic [dataW-1:0] cpuDatOut;
  logic             cpuAck;
  logic             memCyc;
  logic             memStb;
  logic [addrW-1:0] memAdr;
  logic [dataW-1:0] memDatIn;
  logic             memAck;

  logic [tagW-1:0]  modelTag   [numSets][2];  // Reference metadata, index is set then way
  logic             modelValid [numSets][2];
  logic             modelLru   [numSets][2];  // Set means this way goes next
  logic [addrW-1:0] fillAdrs [$];             // Words acked by memory in the current read
  logic             memSeen;                  // memCyc was up during the current read
  logic             stbLast;                  // memStb at the previous falling edge
  int               stbRequests;              // Separate memStb pulses in the current read
  int               fillWords;                // Memory words over the whole run
  int               checks;
  int               errors;
  int               errorsAtStart;
  int               testsRun;
  int               testsFailed;
  bit               aborted;                  // A timeout skips all later reads

  cacheTop UUT (
    .clk      (clk),
    .arstN    (arstN),
    .cpuCyc   (cpuCyc),
    .cpuStb   (cpuStb),
    .cpuAdr   (cpuAdr),
    .cpuDatOut(cpuDatOut),
    .cpuAck   (cpuAck),
    .memCyc   (memCyc),
    .memStb   (memStb),
    .memAdr   (memAdr),
    .memDatIn (memDatIn),
    .memAck   (memAck)
  );

  wbMemory #(.dataKey(dataKey)) memory (
    .clk   (clk),
    .arstN (arstN),
    .cyc   (memCyc),
    .stb   (memStb),
    .adr   (memAdr),
    .datOut(memDatIn),
    .ack   (memAck)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // Memory bus monitor on the falling edge, where all outputs have settled
  always @(negedge clk) begin
    memSeen = memSeen | memCyc;
    if (memStb && !stbLast) begin
      stbRequests++;  // A new request only after stb was low for a cycle
    end
    stbLast = memStb;
    if (memCyc && memStb && memAck) begin
      fillAdrs.push_back(memAdr);
      fillWords++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [dataW-1:0] memWord(logic [addrW-1:0] adr);
    return {1'b0, adr} ^ dataKey;
  endfunction

  function automatic logic [addrW-1:0] makeAdr(logic [tagW-1:0] t, logic [setW-1:0] s);
    return {t, s, wordW'($urandom_range(blockWords - 1, 0))};  // Any word of the block
  endfunction

  // Way that holds the block of adr, or -1 when the block is absent
  function automatic int modelWay(logic [addrW-1:0] adr);
    logic [setW-1:0] s;
    logic [tagW-1:0] t;
    s = adr[wordW +: setW];
    t = adr[addrW-1 -: tagW];
    for (int w = 0; w < 2; w++) begin
      if (modelValid[s][w] && modelTag[s][w] == t) return w;
    end
    return -1;
  endfunction

  // The touched way turns most recent and the other way turns stale
  function automatic void modelAccess(logic [addrW-1:0] adr);
    logic [setW-1:0] s;
    int              w;
    s = adr[wordW +: setW];
    w = modelWay(adr);
    if (w < 0) begin
      w = modelLru[s][0] ? 0 : 1;  // Way 1 also covers the case of no lru bit set
    end
    modelTag[s][w]     = adr[addrW-1 -: tagW];
    modelValid[s][w]   = 1'b1;
    modelLru[s][w]     = 1'b0;
    modelLru[s][1 - w] = 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks and bus tasks
  //////////////////////////////////////////////////////////////////////
  task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic releaseReset;
    @(posedge clk);
    arstN <= 1'b1;
  endtask

  // One CPU read, compared with the model in data, fill words and timing
  task automatic readCheck(logic [addrW-1:0] adr);
    bit               expHit;
    bit               ackSeen;
    int               lat;
    logic [dataW-1:0] got;
    if (aborted) return;
    expHit = (modelWay(adr) >= 0);
    fillAdrs.delete();
    memSeen = 1'b0;
    stbRequests = 0;
    @(posedge clk);
    cpuCyc <= 1'b1;
    cpuStb <= 1'b1;
    cpuAdr <= adr;
    lat    = 0;
    ackSeen = 1'b0;
    while (!ackSeen && lat < ackTimeout) begin
      @(posedge clk);
      lat++;  // Edges since the request was driven
      @(negedge clk);
      ackSeen = cpuAck;
    end
    got = cpuDatOut;
    @(posedge clk);
    cpuCyc <= 1'b0;  // Master drops the strobe after ack
    cpuStb <= 1'b0;
    assert (ackSeen) else begin
      $display("Read of address %h got no cpuAck within %0d cycles", adr, ackTimeout);
      errors++;
      aborted = 1'b1;
    end
    if (aborted) return;
    checkValue("cpuDatOut", 32'(got), 32'(memWord(adr)));
    checkValue("memAck count", 32'(fillAdrs.size()), expHit ? 32'd0 : 32'(blockWords));
    checkValue("memStb count", 32'(stbRequests), expHit ? 32'd0 : 32'(blockWords));
    if (expHit) begin
      checkValue("cpuAck latency", 32'(lat), 32'd1);
      checkValue("memCyc", 32'(memSeen), 32'd0);
    end else begin
      foreach (fillAdrs[i]) begin
        checkValue("memAdr", 32'(fillAdrs[i]), 32'({adr[addrW-1:wordW], wordW'(i)}));
      end
    end
    @(negedge clk);
    checkValue("cpuAck", 32'(cpuAck), 32'd0);  // Ack lasts one cycle only
    modelAccess(adr);
  endtask

  task automatic endTest(string name);
    testsRun++;
    if (errors != errorsAtStart) testsFailed++;
    $display("Test %s: %s", name, (errors == errorsAtStart) ? "ok" : "FAILED");
    errorsAtStart = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [addrW-1:0] adr;
    logic [tagW-1:0]  tagPool [4];
    logic [setW-1:0]  setPool [4];
    int               fillsBefore;
    int               misses;
    void'($urandom(61776));
    cpuCyc = 1'b0;
    cpuStb = 1'b0;
    cpuAdr = '0;
    arstN  = 1'b0;
    memSeen = 1'b0;
    stbLast = 1'b0;
    stbRequests = 0;
    {fillWords, checks, errors, errorsAtStart, testsRun, testsFailed} = '0;
    aborted = 1'b0;
    for (int s = 0; s < numSets; s++) begin
      for (int w = 0; w < 2; w++) begin
        modelTag[s][w]   = '0;  // Same as the cleared arrays after reset
        modelValid[s][w] = 1'b0;
        modelLru[s][w]   = 1'b0;
      end
    end

    // Both buses stay quiet through reset and the idle cycles after it
    for (int c = 0; c < 5; c++) begin
      if (c == 2) releaseReset();
      @(negedge clk);
      checkValue("cpuAck", 32'(cpuAck), 32'd0);
      checkValue("memCyc", 32'(memCyc), 32'd0);
    end
    endTest("resetQuiet");

    adr = addrW'($urandom);
    readCheck(adr);                                  // Cold miss
    readCheck(adr ^ addrW'(1 << wordW));             // Neighbour set is cold too
    endTest("coldMiss");

    fillsBefore = fillWords;
    readCheck(adr);
    readCheck({adr[addrW-1:wordW], ~adr[wordW-1:0]});  // Other word of the same block
    checkValue("memAck count", 32'(fillWords - fillsBefore), 32'd0);
    endTest("repeatHit");

    readCheck(makeAdr(6'h05, 6'd17));
    readCheck(makeAdr(6'h2A, 6'd17));
    fillsBefore = fillWords;
    repeat (4) begin
      readCheck(makeAdr(6'h05, 6'd17));  // Alternating tags both stay resident
      readCheck(makeAdr(6'h2A, 6'd17));
    end
    checkValue("memAck count", 32'(fillWords - fillsBefore), 32'd0);
    endTest("twoTagsResident");

    readCheck(makeAdr(6'h11, 6'd40));
    readCheck(makeAdr(6'h22, 6'd40));
    readCheck(makeAdr(6'h11, 6'd40));    // Tag 22 is now least recent
    readCheck(makeAdr(6'h33, 6'd40));    // Evicts tag 22
    fillsBefore = fillWords;
    readCheck(makeAdr(6'h11, 6'd40));
    checkValue("memAck count", 32'(fillWords - fillsBefore), 32'd0);
    fillsBefore = fillWords;
    readCheck(makeAdr(6'h22, 6'd40));
    checkValue("memAck count", 32'(fillWords - fillsBefore), 32'(blockWords));
    endTest("thirdTagEvicts");

    // Four tags over four sets force hits and evictions alike
    tagPool = '{6'h01, 6'h12, 6'h23, 6'h34};
    setPool = '{6'd3, 6'd17, 6'd40, 6'd63};
    misses = 0;
    fillsBefore = fillWords;
    repeat (300) begin
      adr = makeAdr(tagPool[$urandom_range(3, 0)], setPool[$urandom_range(3, 0)]);
      if (modelWay(adr) < 0) misses++;
      readCheck(adr);
    end
    if (!aborted) begin
      checkValue("memAck count", 32'(fillWords - fillsBefore), 32'(misses * blockWords));
    end
    endTest("randomTraffic");

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim/wbMemory.sv
`timescale 1ns/10ps

// Wishbone classic slave memory with random wait states
// Every word is computed from its address so no storage is needed
module wbMemory #(
  parameter logic [cachePkg::dataW-1:0] dataKey = 16'h5A3C  // Word is address XOR key
) (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic [cachePkg::addrW-1:0] adr,
  output logic [cachePkg::dataW-1:0] datOut,
  output logic                       ack
);
  import cachePkg::*;

  logic [1:0] waitLeft;  // Wait states still owed before the next ack

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ack      <= 1'b0;
      datOut   <= '0;
      waitLeft <= '0;  // First access after reset has no wait
    end else begin
      ack <= 1'b0;  // Ack never lasts more than one cycle
      if (cyc && stb && !ack) begin
        if (waitLeft == 2'd0) begin
          ack      <= 1'b1;
          datOut   <= {1'b0, adr} ^ dataKey;
          waitLeft <= 2'($urandom_range(3, 0));  // Stall for the following word
        end else begin
          waitLeft <= waitLeft - 2'd1;
        end
      end
    end
  end

endmodule
